/* Bender.yml */
package:
  name: sdram_subsys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/sdram_pkg.sv
      - hw/sdram_bus_if.sv
      - hw/sdram_model.sv
      - hw/sdram_ctrl.sv
      - hw/sdram_subsys.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_clock.sv
      - bench/tb_checker.sv
      - bench/tb_sdram_subsys.sv

/* bench/tb_checker.sv */
// ******************************************************************
// Testbench checker for the SDRAM subsystem. Mirrors accepted writes
// in a shadow memory and compares every read beat against it.
// ******************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "sdram_params.svh"

module tb_checker import sdram_pkg::*; (
    input  logic                                 clk,
    input  logic                                 cke,
    input  logic                                 req_valid,
    input  logic                                 req_ready,
    input  logic                                 req_write,
    input  sdram_req_addr_s                      req_addr,
    input  logic [`SDRAM_DQ_W*`SDRAM_BL-1:0]     req_wdata,
    input  logic [`SDRAM_DQ_W/8*`SDRAM_BL-1:0]   req_wmask,
    input  logic                                 rsp_valid,
    input  logic [`SDRAM_DQ_W-1:0]               rsp_data,
    input  logic                                 rsp_last,
    output int                                   mismatch_cnt,
    output int                                   fail_cnt,
    output int                                   accept_cnt,
    output logic                                 read_busy
);

    localparam int DQ_W  = `SDRAM_DQ_W;
    localparam int DM_W  = `SDRAM_DQ_W / 8;
    localparam int NBANK = 2**`SDRAM_BA_W;
    localparam int NROW  = 2**`SDRAM_SIM_ROW_W;
    localparam int NCOL  = 2**`SDRAM_SIM_COL_W;

    logic [DQ_W-1:0] shadow [NBANK][NROW][NCOL];
    logic [DQ_W-1:0] expect_q [$];          // beats of the read in flight
    logic            ready_must_fall;
    int              init_edges;            // rising edges since cke went high

    initial begin
        for (int b = 0; b < NBANK; b++)
            for (int r = 0; r < NROW; r++)
                for (int c = 0; c < NCOL; c++)
                    shadow[b][r][c] = 'x;   // never written
        mismatch_cnt    = 0;
        fail_cnt        = 0;
        accept_cnt      = 0;
        read_busy       = 1'b0;
        ready_must_fall = 1'b0;
        init_edges      = 0;
    end

    // burst columns wrap inside the stored column range
    function automatic int beat_col(input int k);
        return (int'(req_addr.col[`SDRAM_SIM_COL_W-1:0]) + k) % NCOL;
    endfunction

    task automatic store_write();
        int row;
        row = int'(req_addr.row[`SDRAM_SIM_ROW_W-1:0]);
        for (int k = 0; k < `SDRAM_BL; k++) begin
            for (int b = 0; b < DM_W; b++) begin
                if (!req_wmask[k*DM_W + b])  // 1 masks the byte
                    shadow[req_addr.bank][row][beat_col(k)][b*8 +: 8] =
                        req_wdata[k*DQ_W + b*8 +: 8];
            end
        end
    endtask

    task automatic queue_read();
        int row;
        row = int'(req_addr.row[`SDRAM_SIM_ROW_W-1:0]);
        expect_q.delete();
        for (int k = 0; k < `SDRAM_BL; k++)
            expect_q.push_back(shadow[req_addr.bank][row][beat_col(k)]);
    endtask

    always @(posedge clk) begin
        logic [DQ_W-1:0] exp_word;
        logic            exp_last;
        if (!cke) begin
            if (req_ready || rsp_valid || rsp_last) begin
                fail_cnt++;
                $display("%0t: req_ready, rsp_valid or rsp_last high during reset", $time);
            end
        end else begin
            // reset cycle, then LOAD_MODE, then ready
            if (init_edges < 3) begin
                init_edges++;
                if (req_ready !== (init_edges == 3)) begin
                    fail_cnt++;
                    $display("%0t: req_ready out of step with mode programming after reset",
                             $time);
                end
            end

            if (ready_must_fall && req_ready) begin
                fail_cnt++;
                $display("%0t: req_ready stayed high after an accepted request", $time);
            end
            ready_must_fall = 1'b0;

            if (rsp_valid) begin
                if (expect_q.size() == 0) begin
                    fail_cnt++;
                    $display("%0t: read beat returned with no read outstanding", $time);
                end else begin
                    exp_word = expect_q.pop_front();
                    exp_last = (expect_q.size() == 0);
                    if (rsp_data !== exp_word) begin
                        mismatch_cnt++;
                        $display("MISMATCH at %0t: rsp_data = %h, expected %h",
                                 $time, rsp_data, exp_word);
                    end
                    if (rsp_last !== exp_last) begin
                        mismatch_cnt++;
                        $display("MISMATCH at %0t: rsp_last = %b, expected %b",
                                 $time, rsp_last, exp_last);
                    end
                end
            end else if (rsp_last) begin
                fail_cnt++;
                $display("%0t: rsp_last high without rsp_valid", $time);
            end

            if (req_valid && req_ready) begin
                accept_cnt++;
                ready_must_fall = 1'b1;
                if (expect_q.size() != 0) begin
                    fail_cnt++;
                    $display("%0t: request accepted before the read burst finished", $time);
                end
                if (req_write)
                    store_write();
                else
                    queue_read();
            end
            read_busy = (expect_q.size() != 0);
        end
    end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
// ******************************************************************
// Testbench clock and reset source. Free-running 4 ns clk, with cke
// held low over the first two rising edges.
// ******************************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic cke
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;          // 4 ns period
    end

    initial begin
        cke = 1'b0;
        repeat (2) @(negedge clk);      // released away from the rising edge
        cke = 1'b1;
    end

endmodule

`default_nettype wire

/* bench/tb_sdram_subsys.sv */
// ******************************************************************
// Testbench top for the SDRAM subsystem. Sends random read and write
// bursts from a fixed seed and reports the verdict.
// ******************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "sdram_params.svh"

module tb_sdram_subsys import sdram_pkg::*; ();

    localparam int N_REQ       = 200;
    localparam int TIMEOUT_CYC = N_REQ * 12 + 50;

    logic                                clk;
    logic                                cke;
    logic                                req_valid;
    logic                                req_write;
    sdram_req_addr_s                     req_addr;
    logic [`SDRAM_DQ_W*`SDRAM_BL-1:0]    req_wdata;
    logic [`SDRAM_DQ_W/8*`SDRAM_BL-1:0]  req_wmask;
    logic                                req_ready;
    logic                                rsp_valid;
    logic [`SDRAM_DQ_W-1:0]              rsp_data;
    logic                                rsp_last;

    int                                  mismatch_cnt;
    int                                  fail_cnt;
    int                                  accept_cnt;
    logic                                read_busy;
    int                                  seed;
    int                                  sent;
    int                                  cycles;

    tb_clock i_clk (.clk(clk), .cke(cke));

    sdram_subsys i_dut (
        .clk       (clk),
        .cke       (cke),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_wmask (req_wmask),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_last  (rsp_last)
    );

    tb_checker i_chk (
        .clk          (clk),
        .cke          (cke),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_write    (req_write),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_wmask    (req_wmask),
        .rsp_valid    (rsp_valid),
        .rsp_data     (rsp_data),
        .rsp_last     (rsp_last),
        .mismatch_cnt (mismatch_cnt),
        .fail_cnt     (fail_cnt),
        .accept_cnt   (accept_cnt),
        .read_busy    (read_busy)
    );

    // distinct low bits, so no two rows share stored lines
    function automatic logic [`SDRAM_A_W-1:0] pick_row(input int k);
        case (k)
            0:       return 13'h0003;
            1:       return 13'h0046;
            2:       return 13'h1a09;
            default: return 13'h0f1c;
        endcase
    endfunction

    task automatic drive_request();
        logic taken;
        req_valid     = 1'b1;
        req_write     = $random(seed) & 1;
        req_addr.bank = $random(seed) & 3;
        req_addr.row  = pick_row($random(seed) & 3);
        req_addr.col  = ($random(seed) & 7) * 4;        // burst aligned
        req_wdata     = {$random(seed), $random(seed)};
        req_wmask     = $random(seed) & $random(seed);  // a quarter of bytes masked
        do begin
            taken = req_ready;                          // stable until the next edge
            @(negedge clk);
        end while (!taken);
    endtask

    initial begin
        int gap;
        int extra_err;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wmask = '0;
        seed      = 11515;
        sent      = 0;
        extra_err = 0;

        wait (cke);
        @(negedge clk);
        for (int i = 0; i < N_REQ; i++) begin
            gap = ($random(seed) & 32'h7fff_ffff) % 3;  // 0 keeps valid high
            if (gap != 0) begin
                req_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            drive_request();
            sent++;
        end
        req_valid = 1'b0;

        while (read_busy || !req_ready)
            @(negedge clk);

        if (accept_cnt != sent) begin
            extra_err++;
            $display("checker counted %0d accepted requests, but %0d were sent",
                     accept_cnt, sent);
        end
        $display("errors: %0d mismatches, %0d other failures, %0d requests accepted",
                 mismatch_cnt, fail_cnt + extra_err, accept_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0 && extra_err == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial cycles = 0;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYC) begin
            $display("timeout after %0d cycles with %0d of %0d requests sent",
                     cycles, sent, N_REQ);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* hw/sdram_bus_if.sv */
// ******************************************************************
// Pin-level SDRAM bus between controller and device. Each side owns
// a data/enable pair that resolves onto the shared dq net.
// ******************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "sdram_params.svh"

interface sdram_bus_if;

    logic                        cs;
    logic                        ras;
    logic                        cas;
    logic                        we;
    logic [`SDRAM_A_W-1:0]       a;
    logic [`SDRAM_BA_W-1:0]      ba;
    logic [`SDRAM_DQ_W/8-1:0]    dqm;
    tri   [`SDRAM_DQ_W-1:0]      dq;

    logic [`SDRAM_DQ_W-1:0]      ctrl_dq;
    logic                        ctrl_oe;    // write beats only
    logic [`SDRAM_DQ_W-1:0]      mem_dq;
    logic                        mem_oe;     // read beats only

    assign dq = ctrl_oe ? ctrl_dq : 'z;
    assign dq = mem_oe ? mem_dq : 'z;

    modport ctrl (
        output cs, ras, cas, we, a, ba, dqm, ctrl_dq, ctrl_oe,
        input  dq
    );

    modport mem (
        input  cs, ras, cas, we, a, ba, dqm, dq,
        output mem_dq, mem_oe
    );

endinterface

`default_nettype wire

/* hw/sdram_ctrl.sv */
// ******************************************************************
// SDRAM controller. Programs the mode register after reset, then
// takes one burst request at a time, opens rows only on a miss and
// moves write beats out and read beats back on the response port.
// ******************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "sdram_params.svh"

module sdram_ctrl import sdram_pkg::*; (
    input  logic                                 clk,
    input  logic                                 cke,
    input  logic                                 req_valid,
    input  logic                                 req_write,
    input  sdram_req_addr_s                      req_addr,
    input  logic [`SDRAM_DQ_W*`SDRAM_BL-1:0]     req_wdata,
    input  logic [`SDRAM_DQ_W/8*`SDRAM_BL-1:0]   req_wmask,
    output logic                                 req_ready,
    output logic                                 rsp_valid,
    output logic [`SDRAM_DQ_W-1:0]               rsp_data,
    output logic                                 rsp_last,
    sdram_bus_if.ctrl                            bus
);

    localparam int         DQ_W      = `SDRAM_DQ_W;
    localparam int         DM_W      = `SDRAM_DQ_W / 8;
    localparam logic [2:0] LAST_BEAT = 3'(`SDRAM_BL - 1);
    localparam logic [2:0] LAST_WAIT = 3'(`SDRAM_CL - 1);

    typedef enum logic [2:0] {
        ST_INIT, ST_IDLE, ST_ACT, ST_WRITE, ST_RD_WAIT, ST_READ
    } state_e;

    state_e                          state;
    logic [2:0]                      cnt;           // wait cycles, then beats
    sdram_cmd_e                      cmd_q;
    sdram_addr_u                     a_q;
    logic [`SDRAM_BA_W-1:0]          ba_q;
    logic [DM_W-1:0]                 dqm_q;
    logic                            oe_q;
    logic [DQ_W-1:0]                 dq_q;

    logic [2**`SDRAM_BA_W-1:0]       open_flag;
    logic [`SDRAM_A_W-1:0]           open_row [2**`SDRAM_BA_W];

    sdram_req_addr_s                 addr_q;
    logic                            write_q;
    logic [DQ_W*`SDRAM_BL-1:0]       wdata_q;
    logic [DM_W*`SDRAM_BL-1:0]       wmask_q;

    logic                            accept, hit, issue_rw, cur_write;
    sdram_req_addr_s                 cur_addr;
    logic [DQ_W*`SDRAM_BL-1:0]       src_wdata;
    logic [DM_W*`SDRAM_BL-1:0]       src_wmask;
    sdram_addr_u                     mode_word, col_word;

    assign accept   = (state == ST_IDLE) && req_ready && req_valid;
    assign hit      = open_flag[req_addr.bank] && (open_row[req_addr.bank] == req_addr.row);
    assign issue_rw = (state == ST_ACT) || (accept && hit);

    // after ACTIVE the request comes from the holding registers
    assign cur_addr  = (state == ST_ACT) ? addr_q : req_addr;
    assign cur_write = (state == ST_ACT) ? write_q : req_write;
    assign src_wdata = (state == ST_ACT) ? wdata_q : req_wdata;
    assign src_wmask = (state == ST_ACT) ? wmask_q : req_wmask;

    always_comb begin
        mode_word                = '0;
        mode_word.mode.cas_lat   = 3'(`SDRAM_CL);
        mode_word.mode.burst_len = 3'($clog2(`SDRAM_BL));
        col_word                 = '0;
        col_word.col.col_hi      = cur_addr.col[10];
        col_word.col.col_lo      = cur_addr.col[9:0];
    end

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            state     <= ST_INIT;
            cnt       <= 3'd0;
            cmd_q     <= CMD_NOP;
            a_q       <= '0;
            ba_q      <= '0;
            dqm_q     <= '0;
            oe_q      <= 1'b0;
            open_flag <= '0;
            req_ready <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_last  <= 1'b0;
        end else begin
            cmd_q     <= CMD_NOP;
            rsp_valid <= 1'b0;
            rsp_last  <= 1'b0;

            if (issue_rw) begin
                a_q  <= col_word;
                ba_q <= cur_addr.bank;
                cnt  <= 3'd0;
                if (cur_write) begin
                    cmd_q <= CMD_WRITE;
                    oe_q  <= 1'b1;
                    dqm_q <= src_wmask[DM_W-1:0];
                    state <= ST_WRITE;
                end else begin
                    cmd_q <= CMD_READ;
                    dqm_q <= '0;
                    state <= ST_RD_WAIT;
                end
            end

            case (state)
                ST_INIT: begin
                    cmd_q <= CMD_LOAD_MODE;
                    a_q   <= mode_word;
                    state <= ST_IDLE;
                end
                ST_IDLE: begin
                    if (!req_ready) begin
                        req_ready <= 1'b1;
                    end else if (req_valid) begin
                        req_ready <= 1'b0;
                        if (!hit) begin                 // row miss, open it first
                            cmd_q                    <= CMD_ACTIVE;
                            a_q.raw                  <= req_addr.row;
                            ba_q                     <= req_addr.bank;
                            open_flag[req_addr.bank] <= 1'b1;
                            state                    <= ST_ACT;
                        end
                    end
                end
                ST_WRITE: begin
                    if (cnt == LAST_BEAT) begin
                        oe_q      <= 1'b0;
                        dqm_q     <= '0;
                        req_ready <= 1'b1;
                        state     <= ST_IDLE;
                    end else begin
                        dqm_q <= wmask_q[DM_W-1:0];
                        cnt   <= cnt + 3'd1;
                    end
                end
                ST_RD_WAIT: begin
                    if (cnt == LAST_WAIT) begin
                        cnt   <= 3'd0;
                        state <= ST_READ;
                    end else begin
                        cnt <= cnt + 3'd1;
                    end
                end
                ST_READ: begin
                    rsp_valid <= 1'b1;
                    rsp_last  <= (cnt == LAST_BEAT);
                    if (cnt == LAST_BEAT)
                        state <= ST_IDLE;
                    else
                        cnt <= cnt + 3'd1;
                end
                default: ;                              // ST_ACT leaves through issue_rw
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= req_addr;
            write_q <= req_write;
        end
        if (issue_rw) begin
            dq_q    <= src_wdata[DQ_W-1:0];
            wdata_q <= src_wdata >> DQ_W;
            wmask_q <= src_wmask >> DM_W;
        end else if (accept) begin
            wdata_q <= req_wdata;
            wmask_q <= req_wmask;
        end else if (state == ST_WRITE) begin
            dq_q    <= wdata_q[DQ_W-1:0];
            wdata_q <= wdata_q >> DQ_W;
            wmask_q <= wmask_q >> DM_W;
        end
        if (accept && !hit)
            open_row[req_addr.bank] <= req_addr.row;
        if (state == ST_READ)
            rsp_data <= bus.dq;                         // beat is on dq this cycle
    end

    assign {bus.cs, bus.ras, bus.cas, bus.we} = cmd_q;
    assign bus.a       = a_q;
    assign bus.ba      = ba_q;
    assign bus.dqm     = dqm_q;
    assign bus.ctrl_dq = dq_q;
    assign bus.ctrl_oe = oe_q;

    a_no_ready_in_burst : assert property (@(posedge clk) disable iff (!cke)
        (rsp_valid || oe_q || state != ST_IDLE) |-> !req_ready);

    a_nop_between : assert property (@(posedge clk) disable iff (!cke)
        (cmd_q inside {CMD_READ, CMD_WRITE}) |=> (cmd_q == CMD_NOP) until req_ready);

    a_oe_write_only : assert property (@(posedge clk) disable iff (!cke)
        $rose(oe_q) |-> (cmd_q == CMD_WRITE) ##1 oe_q[*(`SDRAM_BL - 1)] ##1 !oe_q);

endmodule

`default_nettype wire

/* hw/sdram_model.sv */
// ******************************************************************
// Behavioral x16 SDRAM with four banks for simulation. Decodes the
// command pins, keeps one open row per bank and runs read and write
// bursts over a reduced storage array.
// ******************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "sdram_params.svh"

module sdram_model import sdram_pkg::*; (
    input  logic       clk,
    input  logic       cke,
    sdram_bus_if.mem   bus
);

    localparam int DM_W  = `SDRAM_DQ_W / 8;
    localparam int ROW_W = `SDRAM_SIM_ROW_W;
    localparam int COL_W = `SDRAM_SIM_COL_W;

    logic [`SDRAM_DQ_W-1:0]  mem [2**`SDRAM_BA_W][2**ROW_W][2**COL_W];
    logic [`SDRAM_A_W-1:0]   row_open [2**`SDRAM_BA_W];
    logic [2**`SDRAM_BA_W-1:0] bank_act;

    sdram_cmd_e              cmd;
    sdram_addr_u             a_u;
    logic                    act_cmd, rd_cmd, wr_cmd, load_cmd;
    logic [`SDRAM_COL_W-1:0] cmd_col;

    logic [2:0]              cl;
    logic [2:0]              bl_code;
    logic [3:0]              burst_last;     // index of final beat

    logic                    wr_busy;
    logic [3:0]              wr_beat;
    logic [`SDRAM_BA_W-1:0]  wr_bank;
    logic [`SDRAM_COL_W-1:0] wr_col;
    logic                    rd_pend;
    logic [2:0]              rd_wait;
    logic [3:0]              rd_beat;
    logic [`SDRAM_BA_W-1:0]  rd_bank;
    logic [`SDRAM_COL_W-1:0] rd_col;

    logic                    wen;
    logic [`SDRAM_BA_W-1:0]  wbank;
    logic [`SDRAM_COL_W-1:0] wcol;

    assign cmd      = sdram_cmd_e'({bus.cs, bus.ras, bus.cas, bus.we});
    assign a_u      = bus.a;
    assign act_cmd  = (cmd == CMD_ACTIVE);
    assign rd_cmd   = (cmd == CMD_READ);
    assign wr_cmd   = (cmd == CMD_WRITE);
    assign load_cmd = (cmd == CMD_LOAD_MODE);
    assign cmd_col  = {a_u.col.col_hi, a_u.col.col_lo};

    assign burst_last = (4'd1 << bl_code) - 4'd1;

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            cl          <= 3'(`SDRAM_CL);
            bl_code     <= 3'd0;
            bank_act    <= '0;
            wr_busy     <= 1'b0;
            wr_beat     <= 4'd0;
            rd_pend     <= 1'b0;
            rd_wait     <= 3'd0;
            rd_beat     <= 4'd0;
            bus.mem_oe  <= 1'b0;
        end else begin
            if (load_cmd) begin
                cl      <= a_u.mode.cas_lat;
                bl_code <= a_u.mode.burst_len;
            end
            if (act_cmd)
                bank_act[bus.ba] <= 1'b1;

            if (wr_cmd) begin                       // beat 0 lands this edge
                wr_busy <= (burst_last != 4'd0);
                wr_beat <= 4'd1;
            end else if (wr_busy) begin
                wr_beat <= wr_beat + 4'd1;
                if (wr_beat == burst_last)
                    wr_busy <= 1'b0;
            end

            if (rd_cmd) begin
                rd_beat <= 4'd0;
                if (cl <= 3'd1) begin
                    bus.mem_oe <= 1'b1;
                end else begin
                    rd_pend <= 1'b1;
                    rd_wait <= cl - 3'd2;
                end
            end else if (rd_pend) begin
                if (rd_wait == 3'd0) begin
                    rd_pend    <= 1'b0;
                    bus.mem_oe <= 1'b1;
                end else begin
                    rd_wait <= rd_wait - 3'd1;
                end
            end else if (bus.mem_oe) begin
                rd_beat <= rd_beat + 4'd1;
                if (rd_beat == burst_last)
                    bus.mem_oe <= 1'b0;             // release dq
            end
        end
    end

    always_ff @(posedge clk) begin
        if (act_cmd)
            row_open[bus.ba] <= bus.a;
        if (wr_cmd) begin
            wr_bank <= bus.ba;
            wr_col  <= cmd_col + 11'd1;
        end else if (wr_busy) begin
            wr_col  <= wr_col + 11'd1;
        end
        if (rd_cmd) begin
            rd_bank <= bus.ba;
            rd_col  <= cmd_col;
        end else if (bus.mem_oe) begin
            rd_col  <= rd_col + 11'd1;
        end
    end

    // write port, command cycle or burst continuation
    assign wen   = wr_cmd || wr_busy;
    assign wbank = wr_cmd ? bus.ba : wr_bank;
    assign wcol  = wr_cmd ? cmd_col : wr_col;

    always_ff @(posedge clk) begin
        if (wen) begin
            for (int b = 0; b < DM_W; b++) begin
                if (!bus.dqm[b])
                    mem[wbank][row_open[wbank][ROW_W-1:0]][wcol[COL_W-1:0]][b*8 +: 8]
                        <= bus.dq[b*8 +: 8];
            end
        end
    end

    assign bus.mem_dq = mem[rd_bank][row_open[rd_bank][ROW_W-1:0]][rd_col[COL_W-1:0]];

    a_bank_open : assert property (@(posedge clk) disable iff (!cke)
        (rd_cmd || wr_cmd) |-> bank_act[bus.ba]);

    a_one_burst : assert property (@(posedge clk) disable iff (!cke)
        (rd_cmd || wr_cmd) |-> !(rd_pend || bus.mem_oe || wr_busy));

endmodule

`default_nettype wire

/* hw/sdram_pkg.sv */
// ******************************************************************
// Types shared by the SDRAM controller, device model and top level:
// pin commands, the address word views and the request address.
// ******************************************************************

`default_nettype none

`include "sdram_params.svh"

package sdram_pkg;

    // {cs, ras, cas, we}
    typedef enum logic [3:0] {
        CMD_NOP       = 4'b1111,    // deselect
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_LOAD_MODE = 4'b0000
    } sdram_cmd_e;

    typedef struct packed {
        logic [2:0] rsvd;           // a12..a10
        logic       write_burst;
        logic [1:0] op_mode;
        logic [2:0] cas_lat;
        logic       burst_type;
        logic [2:0] burst_len;      // log2 of beats
    } sdram_mode_s;

    typedef struct packed {
        logic       rsvd;
        logic       col_hi;         // a11
        logic       auto_pre;       // a10, never set here
        logic [9:0] col_lo;
    } sdram_col_s;

    typedef union packed {
        sdram_mode_s            mode;
        sdram_col_s             col;
        logic [`SDRAM_A_W-1:0]  raw;
    } sdram_addr_u;

    typedef struct packed {
        logic [`SDRAM_BA_W-1:0]  bank;
        logic [`SDRAM_A_W-1:0]   row;
        logic [`SDRAM_COL_W-1:0] col;
    } sdram_req_addr_s;

endpackage

`default_nettype wire

/* hw/sdram_subsys.sv */
// ******************************************************************
// SDRAM subsystem top: controller and device model joined by the
// pin-level bus. Requests in, read beats out, one burst at a time.
// ******************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "sdram_params.svh"

module sdram_subsys import sdram_pkg::*; (
    input  logic                                 clk,
    input  logic                                 cke,
    input  logic                                 req_valid,
    input  logic                                 req_write,
    input  sdram_req_addr_s                      req_addr,
    input  logic [`SDRAM_DQ_W*`SDRAM_BL-1:0]     req_wdata,
    input  logic [`SDRAM_DQ_W/8*`SDRAM_BL-1:0]   req_wmask,   // 1 masks a byte
    output logic                                 req_ready,
    output logic                                 rsp_valid,
    output logic [`SDRAM_DQ_W-1:0]               rsp_data,
    output logic                                 rsp_last
);

    sdram_bus_if i_bus ();

    sdram_ctrl i_ctrl (
        .clk       (clk),
        .cke       (cke),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_wmask (req_wmask),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_last  (rsp_last),
        .bus       (i_bus.ctrl)
    );

    sdram_model i_model (
        .clk (clk),
        .cke (cke),
        .bus (i_bus.mem)
    );

endmodule

`default_nettype wire

/* include/sdram_params.svh */
// ******************************************************************
// Bus widths, programmed mode and simulation array size for the
// SDRAM subsystem. Include wherever a width or the mode is needed.
// ******************************************************************

`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

// pin-level bus widths, x16 part with four banks
`define SDRAM_DQ_W       16
`define SDRAM_A_W        13
`define SDRAM_BA_W       2
`define SDRAM_COL_W      11

// mode programmed by the controller after reset
`define SDRAM_CL         2    // cas latency in clocks
`define SDRAM_BL         4    // beats per burst

// reduced storage in the device model
`define SDRAM_SIM_ROW_W  4
`define SDRAM_SIM_COL_W  6

`endif

/* sdram_subsys.f */
+incdir+include
hw/sdram_pkg.sv
hw/sdram_bus_if.sv
hw/sdram_model.sv
hw/sdram_ctrl.sv
hw/sdram_subsys.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_sdram_subsys.sv
